//--- Makefile
# Verilator build and run for the motion controller testbench

VERILATOR ?= verilator
TOP       ?= motion_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axis_step_dda.sv
// Per-axis DDA with velocity and acceleration accumulation and step output
`timescale 1ns/1ps

module axis_step_dda (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   dda_tick,
  input  logic                   load_move,
  input  logic                   executing,
  input  motion_pkg::axis_rate_t rate,
  output logic                   step
);

  localparam int dda_w = $bits(motion_pkg::dda_t);

  motion_pkg::dda_t acc;    // Position fraction
  motion_pkg::dda_t inc;    // Live increment
  motion_pkg::dda_t accel;
  logic [dda_w:0]   sum;

  // Carry out of the top bit makes a step
  assign sum = {1'b0, acc} + {1'b0, inc};

  always_ff @(posedge CLK) begin
    if (load_move) begin
      acc   <= '0;
      inc   <= rate.increment;
      accel <= rate.accel;
    end else if (dda_tick && executing) begin
      acc <= sum[dda_w-1:0];
      inc <= inc + accel;  // Signed add in two's complement
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step <= 1'b0;
    end else begin
      step <= dda_tick & executing & sum[dda_w];
    end
  end

endmodule

//--- build.f
motion_pkg.sv
axis_step_dda.sv
move_buffer.sv
move_sequencer.sv
motion_cmd_decoder.sv
motion_top.sv
tb_clock_gen.sv
motion_asserts.sv
motion_tb.sv

//--- motion_asserts.sv
// Concurrent checks on move_done width, step gating and buffer_dtr after reset
`timescale 1ns/1ps

module motion_asserts #(
  parameter int num_motors = 2
) (
  input logic                  CLK,
  input logic                  resetn,
  input logic                  move_done,
  input logic                  executing,
  input logic [num_motors-1:0] step,
  input logic                  buffer_dtr
);

  int fail_count = 0;  // Summed into the testbench result

  done_single: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |=> !move_done)
    else begin
      $error("move_done stayed high for two cycles");
      fail_count++;
    end

  // No step pulses outside a move
  step_gated: assert property (@(posedge CLK) disable iff (!resetn)
    !executing |-> (step == '0))
    else begin
      $error("step pulse while no move is executing");
      fail_count++;
    end

  dtr_after_reset: assert property (@(posedge CLK)
    $rose(resetn) |-> ##2 buffer_dtr)
    else begin
      $error("buffer_dtr not high after reset release");
      fail_count++;
    end

endmodule

bind motion_top motion_asserts #(.num_motors(num_motors)) i_asserts (
  .CLK(CLK), .resetn(resetn), .move_done(move_done), .executing(executing),
  .step(step), .buffer_dtr(buffer_dtr)
);

//--- motion_cmd_decoder.sv
// Command decoder with word edge detect, message parser, config and status registers and replies
`timescale 1ns/1ps

module motion_cmd_decoder #(
  parameter int num_motors = 2,
  parameter int buffer_size = 2,
  parameter int default_clock_divisor = 32
) (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  motion_pkg::word_t                       word_data,
  input  logic                                    word_received,
  output motion_pkg::word_t                       word_send_data,
  input  logic                                    slot_free,
  output logic                                    move_push,
  output logic [num_motors-1:0]                   move_dir,
  output motion_pkg::move_hdr_t                   move_hdr,
  output motion_pkg::axis_rate_t [num_motors-1:0] move_rate,
  output logic [num_motors-1:0]                   enable,
  output motion_pkg::divisor_t                    clock_divisor
);

  // Index of the last word after a move header
  localparam logic [7:0] last_move_word = 8'(2 * num_motors);

  logic                         word_received_q;
  logic                         word_received_qq;
  logic                         word_rise;
  motion_pkg::header_t          hdr;
  logic                         msg_open;     // Multi-word message in progress
  motion_pkg::cmd_t             msg_hdr;
  logic [7:0]                   word_cnt;     // Words seen after the header
  logic [7:0]                   cfg_addr;
  logic [num_motors-1:0]        cfg_enable;
  motion_pkg::divisor_t         cfg_clocks;
  motion_pkg::word_t            status_reply;
  motion_pkg::word_t            config_reply;

  assign word_rise = word_received_q & ~word_received_qq;
  assign hdr = word_data[63:56];

  assign enable = cfg_enable;
  assign clock_divisor = cfg_clocks;

  // Status lookup on the low byte of the header word
  always_comb begin
    status_reply = '0;
    case (word_data[7:0])
      motion_pkg::STATUS_VERSION: status_reply[31:0] = motion_pkg::VERSION_WORD;
      motion_pkg::STATUS_CHANNEL_INFO: begin
        status_reply[7:0]  = 8'(num_motors);
        status_reply[15:8] = 8'(buffer_size);
      end
      default: status_reply = '0;
    endcase
  end

  always_comb begin
    config_reply = '0;
    case (word_data[7:0])
      motion_pkg::CONFIG_ENABLE: config_reply[num_motors-1:0] = cfg_enable;
      motion_pkg::CONFIG_CLOCKS: config_reply[7:0] = cfg_clocks;
      default: config_reply = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_received_q  <= 1'b0;
      word_received_qq <= 1'b0;
    end else begin
      word_received_q  <= word_received;
      word_received_qq <= word_received_q;
    end
  end

  // Message state, config registers and reply word
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_send_data <= '0;
      move_push      <= 1'b0;
      msg_open       <= 1'b0;
      msg_hdr        <= motion_pkg::CMD_STATUS_REG;
      word_cnt       <= '0;
      cfg_enable     <= '0;
      cfg_clocks     <= motion_pkg::divisor_t'(default_clock_divisor);
    end else begin
      move_push <= 1'b0;
      if (word_rise) begin
        word_send_data <= '0;  // Data words reply zero
        if (!msg_open) begin
          word_cnt <= '0;
          case (hdr)
            motion_pkg::CMD_STATUS_REG: word_send_data <= status_reply;
            motion_pkg::CMD_CONFIG_REG: begin
              word_send_data <= config_reply;
              msg_open       <= 1'b1;
              msg_hdr        <= motion_pkg::CMD_CONFIG_REG;
            end
            motion_pkg::CMD_COORDINATED_STEP: begin
              msg_open <= 1'b1;
              msg_hdr  <= motion_pkg::CMD_COORDINATED_STEP;
            end
            default: ;  // Unknown header opens nothing
          endcase
        end else if (msg_hdr == motion_pkg::CMD_CONFIG_REG) begin
          msg_open <= 1'b0;
          case (cfg_addr)
            motion_pkg::CONFIG_ENABLE: cfg_enable <= word_data[num_motors-1:0];
            motion_pkg::CONFIG_CLOCKS: cfg_clocks <= word_data[7:0];
            default: ;
          endcase
        end else begin
          word_cnt <= word_cnt + 8'd1;
          if (word_cnt == last_move_word) begin
            msg_open  <= 1'b0;
            move_push <= slot_free;  // Move dropped when the buffer is full
          end
        end
      end
    end
  end

  // Move staging and config address
  always_ff @(posedge CLK) begin
    if (word_rise) begin
      if (!msg_open) begin
        cfg_addr <= word_data[7:0];
        if (hdr == motion_pkg::CMD_COORDINATED_STEP) begin
          move_dir <= word_data[num_motors-1:0];
        end
      end else if (msg_hdr == motion_pkg::CMD_COORDINATED_STEP) begin
        if (word_cnt == 8'd0) begin
          move_hdr.duration <= word_data[31:0];
        end
        // Increment then accel for each axis in turn
        for (int a = 0; a < num_motors; a++) begin
          if (word_cnt == 8'(2 * a + 1)) begin
            move_rate[a].increment <= word_data;
          end
          if (word_cnt == 8'(2 * a + 2)) begin
            move_rate[a].accel <= word_data;
          end
        end
      end
    end
  end

endmodule

//--- motion_pkg.sv
// Bus word and DDA widths, command headers, register addresses, move structs
package motion_pkg;

  typedef logic [63:0] word_t;      // One bus word
  typedef logic [7:0]  header_t;    // Top byte of a header word
  typedef logic [31:0] duration_t;  // Move length in DDA ticks
  typedef logic [63:0] dda_t;       // Increment or accel, read as signed
  typedef logic [7:0]  divisor_t;   // Clock cycles per DDA tick

  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_STATUS_REG       = 8'hF1,
    CMD_CONFIG_REG       = 8'hF2
  } cmd_t;

  // Status register addresses
  localparam logic [7:0] STATUS_VERSION      = 8'd0;
  localparam logic [7:0] STATUS_CHANNEL_INFO = 8'd1;

  // Config register addresses
  // Address 1 is unused and reads zero
  localparam logic [7:0] CONFIG_ENABLE = 8'd0;
  localparam logic [7:0] CONFIG_CLOCKS = 8'd2;

  // Devel, major, minor, patch from the top byte down
  localparam logic [31:0] VERSION_WORD = {8'd0, 8'd1, 8'd0, 8'd0};

  // Rate of one axis within one move
  typedef struct packed {
    dda_t increment;
    dda_t accel;
  } axis_rate_t;

  // Part of a move shared by all axes
  typedef struct packed {
    duration_t duration;
  } move_hdr_t;

endpackage

//--- motion_tb.sv
// Testbench top: DUT, word stimulus tasks, step and pulse monitor, checks and summary
`timescale 1ns/1ps

module motion_tb;

  localparam int nm = 2;
  localparam int bs = 2;
  localparam int wait_limit = 5000;  // Cycles allowed for any wait

  logic                  CLK;
  logic                  resetn;
  motion_pkg::word_t     word_data;
  logic                  word_received;
  motion_pkg::word_t     word_send_data;
  logic [nm-1:0]         step;
  logic [nm-1:0]         dir;
  logic [nm-1:0]         enable;
  logic                  buffer_dtr;
  logic                  move_done;

  motion_pkg::word_t     reply;
  logic [nm-1:0]         exp_dir;
  int                    errors = 0;
  int                    timeouts = 0;
  int                    done_cnt = 0;
  int                    step_cnt [nm] = '{default: 0};

  tb_clock_gen #(.period_ns(40), .reset_cycles(16)) i_clock_gen (.CLK(CLK), .resetn(resetn));

  motion_top #(.num_motors(nm), .buffer_size(bs), .default_clock_divisor(4)) i_motion_top (
    .CLK(CLK), .resetn(resetn), .word_data(word_data), .word_received(word_received),
    .word_send_data(word_send_data), .step(step), .dir(dir), .enable(enable),
    .buffer_dtr(buffer_dtr), .move_done(move_done)
  );

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // Steps and move_done pulses, dir checked on every step
  always @(negedge CLK) begin
    if (resetn) begin
      if (move_done) done_cnt++;
      for (int a = 0; a < nm; a++) begin
        if (step[a]) begin
          step_cnt[a]++;
          check_value("dir", 64'(dir[a]), 64'(exp_dir[a]));
        end
      end
    end
  end

  // Carries of the 64-bit accumulator, increment grows by accel after each tick
  function automatic int count_steps(input motion_pkg::duration_t dur,
                                     input motion_pkg::dda_t inc0, input motion_pkg::dda_t accel);
    logic [64:0] sum;
    logic [63:0] acc;
    logic [63:0] inc;
    int          n;
    int          ticks;
    acc = '0;
    inc = inc0;
    n = 0;
    ticks = (dur == 0) ? 1 : int'(dur);  // Zero length still runs one tick
    for (int t = 0; t < ticks; t++) begin
      sum = {1'b0, acc} + {1'b0, inc};
      if (sum[64]) n++;
      acc = sum[63:0];
      inc = inc + accel;
    end
    return n;
  endfunction

  // High for 4 cycles, low for 4, reply taken at the end of the low phase
  task automatic send_word(input motion_pkg::word_t w, output motion_pkg::word_t r);
    @(posedge CLK);
    word_data     <= w;
    word_received <= 1'b1;
    repeat (4) @(posedge CLK);
    word_received <= 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    r = word_send_data;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!resetn && n < wait_limit) begin
      @(negedge CLK);
      n++;
    end
    if (!resetn) begin
      $display("Timeout waiting for reset release");
      timeouts++;
    end
  endtask

  task automatic wait_dtr();
    int n;
    n = 0;
    while (!buffer_dtr && n < wait_limit) begin
      @(negedge CLK);
      n++;
    end
    if (!buffer_dtr) begin
      $display("Timeout waiting for a free move buffer slot");
      timeouts++;
    end
  endtask

  task automatic wait_done(input int target);
    int n;
    n = 0;
    while (done_cnt < target && n < wait_limit) begin
      @(negedge CLK);
      n++;
    end
    if (done_cnt < target) begin
      $display("Timeout waiting for move_done");
      timeouts++;
    end
  endtask

  task automatic status_read(input logic [7:0] addr, input motion_pkg::word_t exp);
    motion_pkg::word_t r;
    send_word({8'(motion_pkg::CMD_STATUS_REG), 48'h0, addr}, r);
    check_value("word_send_data", r, exp);
  endtask

  // Header returns the old value, the data word writes
  task automatic config_access(input logic [7:0] addr, input motion_pkg::word_t data,
                               input motion_pkg::word_t exp_old);
    motion_pkg::word_t r;
    send_word({8'(motion_pkg::CMD_CONFIG_REG), 48'h0, addr}, r);
    check_value("word_send_data", r, exp_old);
    send_word(data, r);
    check_value("word_send_data", r, '0);
  endtask

  task automatic send_move(input logic [nm-1:0] d, input motion_pkg::duration_t dur,
                           input motion_pkg::dda_t inc0, input motion_pkg::dda_t acc0,
                           input motion_pkg::dda_t inc1, input motion_pkg::dda_t acc1);
    motion_pkg::word_t words [6];
    motion_pkg::word_t r;
    words[0] = {8'(motion_pkg::CMD_COORDINATED_STEP), 56'(d)};
    words[1] = 64'(dur);
    words[2] = inc0;
    words[3] = acc0;
    words[4] = inc1;
    words[5] = acc1;
    wait_dtr();
    exp_dir = d;
    for (int i = 0; i < 6; i++) begin
      send_word(words[i], r);
      check_value("word_send_data", r, '0);
    end
  endtask

  task automatic run_move(input logic [nm-1:0] d, input motion_pkg::duration_t dur,
                          input motion_pkg::dda_t inc0, input motion_pkg::dda_t acc0,
                          input motion_pkg::dda_t inc1, input motion_pkg::dda_t acc1);
    int base_done;
    int base0;
    int base1;
    base_done = done_cnt;
    base0 = step_cnt[0];
    base1 = step_cnt[1];
    send_move(d, dur, inc0, acc0, inc1, acc1);
    wait_done(base_done + 1);
    repeat (8) @(negedge CLK);
    check_count("move_done", done_cnt - base_done, 1);
    check_count("step[0]", step_cnt[0] - base0, count_steps(dur, inc0, acc0));
    check_count("step[1]", step_cnt[1] - base1, count_steps(dur, inc1, acc1));
  endtask

  initial begin
    int base_done;
    word_data     = '0;
    word_received = 1'b0;
    exp_dir       = '0;
    wait_reset();
    check_value("word_send_data", word_send_data, '0);
    check_value("enable", 64'(enable), '0);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'h1);

    // Status registers, unknown header right after a nonzero reply
    status_read(motion_pkg::STATUS_VERSION, {32'h0, motion_pkg::VERSION_WORD});
    send_word({8'h55, 56'h0}, reply);
    check_value("word_send_data", reply, '0);
    status_read(motion_pkg::STATUS_CHANNEL_INFO, {48'h0, 8'(bs), 8'(nm)});
    status_read(8'h07, '0);

    config_access(motion_pkg::CONFIG_CLOCKS, 64'h1FF, 64'h4);
    config_access(motion_pkg::CONFIG_CLOCKS, 64'h4, 64'hFF);  // Read back, divisor back to 4
    config_access(motion_pkg::CONFIG_ENABLE, 64'h7, '0);
    @(negedge CLK);
    check_value("enable", 64'(enable), 64'h3);

    run_move(2'b10, 32'd16, 64'h4000_0000_0000_0000, '0, 64'h8000_0000_0000_0000, '0);
    run_move(2'b01, 32'd20, '0, 64'h1000_0000_0000_0000, '0, 64'h0800_0000_0000_0000);

    // Slow ticks so that the second move finds the first still running
    config_access(motion_pkg::CONFIG_CLOCKS, 64'd200, 64'h4);
    base_done = done_cnt;
    send_move(2'b11, 32'd3, 64'h8000_0000_0000_0000, '0, 64'h8000_0000_0000_0000, '0);
    send_move(2'b11, 32'd3, 64'h4000_0000_0000_0000, '0, 64'h8000_0000_0000_0000, '0);
    check_value("buffer_dtr", 64'(buffer_dtr), '0);
    wait_done(base_done + 2);
    repeat (4) @(negedge CLK);
    check_count("move_done", done_cnt - base_done, 2);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'h1);

    $display("Errors %0d, timeouts %0d, assertion failures %0d",
             errors, timeouts, i_motion_top.i_asserts.fail_count);
    if (errors == 0 && timeouts == 0 && i_motion_top.i_asserts.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- motion_top.sv
// Motion controller top: decoder, move buffer, sequencer and one DDA per axis
`timescale 1ns/1ps

module motion_top #(
  parameter int num_motors = 2,
  parameter int buffer_size = 2,
  parameter int default_clock_divisor = 32
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  motion_pkg::word_t     word_data,
  input  logic                  word_received,
  output motion_pkg::word_t     word_send_data,
  output logic [num_motors-1:0] step,
  output logic [num_motors-1:0] dir,
  output logic [num_motors-1:0] enable,
  output logic                  buffer_dtr,
  output logic                  move_done
);

  logic                                    move_push;
  logic [num_motors-1:0]                   move_dir;
  motion_pkg::move_hdr_t                   move_hdr;
  motion_pkg::axis_rate_t [num_motors-1:0] move_rate;
  motion_pkg::divisor_t                    clock_divisor;
  logic                                    slot_full;
  logic [num_motors-1:0]                   out_dir;
  motion_pkg::move_hdr_t                   out_hdr;
  motion_pkg::axis_rate_t [num_motors-1:0] out_rate;
  logic                                    move_pop;
  logic                                    dda_tick;
  logic                                    load_move;
  logic                                    executing;

  motion_cmd_decoder #(
    .num_motors(num_motors),
    .buffer_size(buffer_size),
    .default_clock_divisor(default_clock_divisor)
  ) i_decoder (
    .CLK(CLK), .resetn(resetn),
    .word_data(word_data), .word_received(word_received), .word_send_data(word_send_data),
    .slot_free(buffer_dtr), .move_push(move_push), .move_dir(move_dir),
    .move_hdr(move_hdr), .move_rate(move_rate),
    .enable(enable), .clock_divisor(clock_divisor)
  );

  move_buffer #(.num_motors(num_motors), .buffer_size(buffer_size)) i_buffer (
    .CLK(CLK), .resetn(resetn),
    .move_push(move_push), .move_dir(move_dir), .move_hdr(move_hdr), .move_rate(move_rate),
    .move_pop(move_pop), .slot_full(slot_full),
    .out_dir(out_dir), .out_hdr(out_hdr), .out_rate(out_rate), .buffer_dtr(buffer_dtr)
  );

  move_sequencer i_sequencer (
    .CLK(CLK), .resetn(resetn),
    .clock_divisor(clock_divisor), .slot_full(slot_full), .out_hdr(out_hdr),
    .move_pop(move_pop), .dda_tick(dda_tick), .load_move(load_move),
    .executing(executing), .move_done(move_done)
  );

  for (genvar a = 0; a < num_motors; a++) begin : g_axis
    axis_step_dda i_dda (
      .CLK(CLK), .resetn(resetn),
      .dda_tick(dda_tick), .load_move(load_move), .executing(executing),
      .rate(out_rate[a]), .step(step[a])
    );
  end

  assign dir = executing ? out_dir : '0;  // Directions only during a move

endmodule

//--- move_buffer.sv
// Circular move buffer with write and read slot pointers and a ready mask
`timescale 1ns/1ps

module move_buffer #(
  parameter int num_motors = 2,
  parameter int buffer_size = 2
) (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  logic                                    move_push,
  input  logic [num_motors-1:0]                   move_dir,
  input  motion_pkg::move_hdr_t                   move_hdr,
  input  motion_pkg::axis_rate_t [num_motors-1:0] move_rate,
  input  logic                                    move_pop,
  output logic                                    slot_full,
  output logic [num_motors-1:0]                   out_dir,
  output motion_pkg::move_hdr_t                   out_hdr,
  output motion_pkg::axis_rate_t [num_motors-1:0] out_rate,
  output logic                                    buffer_dtr
);

  localparam int ptr_w = (buffer_size > 1) ? $clog2(buffer_size) : 1;
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(buffer_size - 1);

  logic [ptr_w-1:0]                        wr_ptr;
  logic [ptr_w-1:0]                        rd_ptr;
  logic [buffer_size-1:0]                  ready;  // One bit per filled slot
  logic                                    do_push;
  logic                                    do_pop;
  logic [num_motors-1:0]                   dir_mem [buffer_size];
  motion_pkg::move_hdr_t                   hdr_mem [buffer_size];
  motion_pkg::axis_rate_t [num_motors-1:0] rate_mem [buffer_size];

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    return (p == last_slot) ? '0 : p + 1'b1;
  endfunction

  assign do_push = move_push & ~ready[wr_ptr];
  assign do_pop  = move_pop & ready[rd_ptr];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      ready  <= '0;
    end else begin
      // Push and pop never hit the same slot
      if (do_push) begin
        ready[wr_ptr] <= 1'b1;
        wr_ptr        <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        ready[rd_ptr] <= 1'b0;
        rd_ptr        <= next_ptr(rd_ptr);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      dir_mem[wr_ptr]  <= move_dir;
      hdr_mem[wr_ptr]  <= move_hdr;
      rate_mem[wr_ptr] <= move_rate;
    end
  end

  assign slot_full  = ready[rd_ptr];
  assign out_dir    = dir_mem[rd_ptr];
  assign out_hdr    = hdr_mem[rd_ptr];
  assign out_rate   = rate_mem[rd_ptr];
  assign buffer_dtr = ~&ready;  // Room for one more move

endmodule

//--- move_sequencer.sv
// DDA tick divider and move FSM that times each move and frees its slot
`timescale 1ns/1ps

module move_sequencer (
  input  logic                  CLK,
  input  logic                  resetn,
  input  motion_pkg::divisor_t  clock_divisor,
  input  logic                  slot_full,
  input  motion_pkg::move_hdr_t out_hdr,
  output logic                  move_pop,
  output logic                  dda_tick,
  output logic                  load_move,
  output logic                  executing,
  output logic                  move_done
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,
    S_RUN
  } state_t;

  state_t                state;
  motion_pkg::divisor_t  div_q;     // Divisor the counter runs on
  motion_pkg::divisor_t  tick_cnt;
  logic                  tick_q;
  motion_pkg::duration_t dur_cnt;   // Ticks left in the move
  logic                  ending;    // Cycle after the last tick

  // Tick divider, restarts when the divisor changes
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_q    <= clock_divisor;
      tick_cnt <= '0;
      tick_q   <= 1'b0;
    end else if (clock_divisor != div_q) begin
      div_q    <= clock_divisor;
      tick_cnt <= '0;
      tick_q   <= 1'b0;
    end else if (tick_cnt == clock_divisor - 1'b1) begin
      tick_cnt <= '0;
      tick_q   <= 1'b1;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      tick_q   <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state     <= S_IDLE;
      ending    <= 1'b0;
      move_done <= 1'b0;
    end else begin
      move_done <= move_pop;
      case (state)
        S_IDLE: if (slot_full) state <= S_LOAD;
        S_LOAD: state <= S_RUN;
        S_RUN: begin
          if (ending) begin
            state  <= S_IDLE;
            ending <= 1'b0;
          end else if (tick_q && dur_cnt <= 1) begin
            ending <= 1'b1;  // Zero length also ends on this tick
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (load_move) begin
      dur_cnt <= out_hdr.duration;
    end else if (executing && tick_q && dur_cnt > 1) begin
      dur_cnt <= dur_cnt - 1'b1;
    end
  end

  assign load_move = (state == S_LOAD);
  assign executing = (state == S_RUN);
  assign move_pop  = executing & ending;  // Last step pulse stays inside the move
  assign dda_tick  = tick_q & ~ending;

endmodule

//--- tb_clock_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns = 40,
  parameter int reset_cycles = 16
) (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #(period_ns / 2) CLK = ~CLK;
  end

  // Released on a rising edge
  initial begin
    resetn = 1'b0;
    repeat (reset_cycles) @(posedge CLK);
    resetn <= 1'b1;
  end

endmodule
